/* Bender.yml */
package:
  name: dcache

sources:
  - files:
      - logic/cache_pkg.sv
      - logic/single_port_ram.sv
      - logic/dcache.sv
      - logic/burst_memory.sv
      - logic/dcache_subsystem.sv
  - target: test
    files:
      - bench/dcache_asserts.sv
      - bench/tb_dcache.sv

/* bench/dcache_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_asserts import cache_pkg::*; (
	input logic clk,
	input logic reset,
	input dbus_req_t dreq,
	input dbus_resp_t dresp,
	input cbus_req_t creq,
	input cbus_resp_t cresp,
	input logic [word_bits-1:0] counter
);

	// number of assertion failures so far
	int fail_count = 0;

	// cache bus idle right after reset
	assert property (@(posedge clk) reset |=> !creq.valid)
		else begin
			fail_count++;
			$error("creq.valid high in the cycle after reset");
		end

	// burst fields held while waiting for ready
	assert property (@(posedge clk) disable iff (reset)
		creq.valid && !cresp.ready |=>
		$stable(creq.addr) && $stable(creq.len) && $stable(creq.burst))
		else begin
			fail_count++;
			$error("creq addr, len or burst changed before ready");
		end

	// no completion without a request or while a bus beat is still pending
	assert property (@(posedge clk) disable iff (reset)
		dresp.data_ok |-> dreq.valid && (!creq.valid || cresp.ready))
		else begin
			fail_count++;
			$error("data_ok high without dreq.valid or before the bus beat");
		end

	// last only on a transferred beat that the cache also counts as final
	assert property (@(posedge clk) disable iff (reset)
		cresp.last |-> cresp.ready && counter == word_bits'(creq.len))
		else begin
			fail_count++;
			$error("cresp.last without cresp.ready or off the final beat");
		end

endmodule

bind dcache dcache_asserts dcache_asserts_inst (
	.clk,
	.reset,
	.dreq,
	.dresp,
	.creq,
	.cresp,
	.counter
);

`default_nettype wire

/* bench/tb_dcache.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dcache import cache_pkg::*; ();

	logic clk;
	logic reset;
	dbus_req_t dreq;
	dbus_resp_t dresp;

	// shadow of the cached window and the device window
	word_t shadow_mem [mem_words];
	word_t shadow_dev [dev_words];

	logic [31:0] rng_state;
	string test_name;
	int value_errors = 0;
	int hit_errors = 0;
	int accept_errors = 0;
	int timeouts = 0;
	int reads_checked = 0;

	dcache_subsystem dcache_subsystem_inst (
		.clk(clk),
		.reset(reset),
		.dreq(dreq),
		.dresp(dresp)
	);

	// 4 ns clock
	always #2 clk = ~clk;

	// xorshift32
	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic word_t rand_word();
		word_t result;
		result[63:32] = next_rand();
		result[31:0] = next_rand();
		return result;
	endfunction

	// cacheable means 0x0000_0000_8xxx_xxxx
	function automatic logic is_cached(addr_t addr);
		return addr[63:32] == 32'd0 && addr[31:28] == 4'h8;
	endfunction

	// reference model for the expected read word
	function automatic word_t expected_read(addr_t addr);
		if (is_cached(addr)) begin
			return shadow_mem[addr[11:3]];
		end
		return shadow_dev[addr[6:3]];
	endfunction

	function automatic word_t merge_bytes(word_t old, word_t wdata, strobe_t strobe);
		word_t result;
		result = old;
		for (int i = 0; i < 8; i++) begin
			if (strobe[i]) begin
				result[8*i +: 8] = wdata[8*i +: 8];
			end
		end
		return result;
	endfunction

	task automatic check_word(string name, word_t expected, word_t actual);
		if (actual !== expected) begin
			value_errors++;
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic check_hit(string name, logic expected, logic actual);
		if (actual !== expected) begin
			hit_errors++;
			$display("[ERROR] %s: expected same-cycle data_ok %b, actual %b",
				name, expected, actual);
		end
	endtask

	task automatic check_accept(string name, logic expected, logic actual);
		if (actual !== expected) begin
			accept_errors++;
			$display("[ERROR] %s: expected addr_ok %b, actual %b", name, expected, actual);
		end
	endtask

	// compare process sees one completion per negedge with data_ok
	always @(negedge clk) begin
		if (!reset) begin
			check_accept(test_name, 1'b1, dresp.addr_ok);
		end
		if (!reset && dreq.valid && dresp.data_ok) begin
			if (dreq.strobe == '0) begin
				check_word(test_name, expected_read(dreq.addr), dresp.data);
				reads_checked++;
			end else if (is_cached(dreq.addr)) begin
				shadow_mem[dreq.addr[11:3]] =
					merge_bytes(shadow_mem[dreq.addr[11:3]], dreq.data, dreq.strobe);
			end else begin
				shadow_dev[dreq.addr[6:3]] =
					merge_bytes(shadow_dev[dreq.addr[6:3]], dreq.data, dreq.strobe);
			end
		end
	end

	// one request held until data_ok, then valid dropped
	task automatic access(addr_t addr, strobe_t strobe, word_t wdata, output logic at_once);
		int waited;
		logic done;
		waited = 0;
		done = 1'b0;
		@(posedge clk);
		dreq.valid <= 1'b1;
		dreq.addr <= addr;
		dreq.size <= msize_8;
		dreq.strobe <= strobe;
		dreq.data <= wdata;
		// writeback plus fetch is about 21 cycles
		while (!done && waited < 100) begin
			@(negedge clk);
			if (dresp.data_ok) begin
				done = 1'b1;
			end else begin
				waited++;
			end
		end
		at_once = done && waited == 0;
		if (!done) begin
			timeouts++;
			$display("%s: no data_ok within 100 cycles for address %h", test_name, addr);
		end
		@(posedge clk);
		dreq.valid <= 1'b0;
	endtask

	initial begin
		logic at_once;
		cache_addr_u conflict_a;
		cache_addr_u conflict_b;
		addr_t addr;
		logic [31:0] pick;
		strobe_t strobe;
		int assert_fails;
		clk = 1'b0;
		reset = 1'b1;
		dreq = '0;
		rng_state = 32'd14474;
		repeat (10) @(posedge clk);
		reset <= 1'b0;

		// every cached word written and then read back
		test_name = "fill";
		for (int i = 0; i < mem_words; i++) begin
			access(64'h8000_0000 + 64'(i) * 8, 8'hff, rand_word(), at_once);
		end
		test_name = "read back";
		for (int i = 0; i < mem_words; i++) begin
			access(64'h8000_0000 + 64'(i) * 8, 8'h00, '0, at_once);
		end

		// random strobes on cached words
		test_name = "partial write";
		for (int i = 0; i < 64; i++) begin
			addr = 64'h8000_0000 + 64'(next_rand() % mem_words) * 8;
			strobe = strobe_t'(next_rand());
			access(addr, (strobe == 8'h00) ? 8'h0f : strobe, rand_word(), at_once);
			access(addr, 8'h00, '0, at_once);
		end

		// neighbour word in the same line must hit at once
		test_name = "hit timing";
		for (int i = 0; i < 32; i++) begin
			addr = 64'h8000_0000 + 64'(next_rand() % mem_words) * 8;
			access(addr, 8'h00, '0, at_once);
			access(addr ^ 64'h8, 8'h00, '0, at_once);
			check_hit(test_name, 1'b1, at_once);
		end

		// two tags fighting over one index
		test_name = "conflict eviction";
		for (int idx = 0; idx < 4; idx++) begin
			conflict_a.raw = 64'h8000_0000;
			conflict_a.field.index = index_bits'(idx * 5);
			conflict_a.field.word = word_bits'(idx + 1);
			conflict_a.field.tag = tag_bits'(1);
			conflict_b = conflict_a;
			conflict_b.field.tag = tag_bits'(3);
			for (int round = 0; round < 3; round++) begin
				access(conflict_a.raw, 8'hff, rand_word(), at_once);
				access(conflict_b.raw, 8'hff, rand_word(), at_once);
			end
			access(conflict_a.raw, 8'h00, '0, at_once);
			access(conflict_b.raw, 8'h00, '0, at_once);
		end

		// device window with single uncached beats
		test_name = "device";
		for (int i = 0; i < dev_words; i++) begin
			access(64'h1000_0000 + 64'(i) * 8, 8'hff, rand_word(), at_once);
		end
		for (int i = 0; i < dev_words; i++) begin
			addr = 64'h1000_0000 + 64'(i) * 8;
			access(addr, 8'h3c ^ 8'(i), rand_word(), at_once);
			access(addr, 8'h00, '0, at_once);
		end

		// mixed random traffic with about a quarter to the device
		test_name = "random mix";
		for (int i = 0; i < 400; i++) begin
			pick = next_rand();
			if (pick[1:0] == 2'd0) begin
				addr = 64'h1000_0000 + 64'(pick[7:4]) * 8;
			end else begin
				addr = 64'h8000_0000 + 64'(pick[16:8]) * 8;
			end
			if (pick[2]) begin
				strobe = strobe_t'(next_rand());
				access(addr, (strobe == 8'h00) ? 8'hff : strobe, rand_word(), at_once);
			end else begin
				access(addr, 8'h00, '0, at_once);
			end
		end

		repeat (2) @(posedge clk);
		assert_fails = dcache_subsystem_inst.dcache_inst.dcache_asserts_inst.fail_count;
		$display("reads %0d, errors value %0d hit %0d addr_ok %0d timeout %0d assertion %0d",
			reads_checked, value_errors, hit_errors, accept_errors, timeouts,
			assert_fails);
		if (value_errors + hit_errors + accept_errors + timeouts + assert_fails == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* logic/burst_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module burst_memory import cache_pkg::*; (
	input logic clk,
	input logic reset,
	input cbus_req_t creq,
	output cbus_resp_t cresp
);

	// backing store for the cached window
	word_t mem [mem_words];
	// device registers selected by address bit 28
	word_t dev [dev_words];

	// high while beats are being transferred
	logic active;
	// beats done so far in this transaction
	logic [7:0] beat;
	logic [7:0] step;

	logic dev_sel;
	logic [mem_index_bits-1:0] mem_idx;
	logic [dev_index_bits-1:0] dev_idx;
	logic final_beat;

	// address decode
	// upper bits beyond the windows alias
	assign dev_sel = creq.addr[28];
	// fixed bursts stay on one word
	assign step = (creq.burst == burst_incr) ? beat : 8'd0;
	assign mem_idx = creq.addr[mem_index_bits+align_bits-1:align_bits] + mem_index_bits'(step);
	assign dev_idx = creq.addr[dev_index_bits+align_bits-1:align_bits] + dev_index_bits'(step);

	assign final_beat = beat == creq.len;

	// sequencer
	// idle with valid is the accept cycle, ready follows from the next one
	always_ff @(posedge clk) begin
		if (reset) begin
			active <= 1'b0;
			beat <= '0;
		end else if (!active) begin
			beat <= '0;
			if (creq.valid) begin
				active <= 1'b1;
			end
		end else if (final_beat) begin
			// back to idle, so ready drops for at least a cycle
			active <= 1'b0;
			beat <= '0;
		end else begin
			beat <= beat + 8'd1;
		end
	end

	// response
	assign cresp.ready = active;
	assign cresp.last = active && final_beat;
	assign cresp.data = dev_sel ? dev[dev_idx] : mem[mem_idx];

	// write beats land on the ready cycle
	always_ff @(posedge clk) begin
		if (active && creq.is_write) begin
			for (int i = 0; i < 8; i++) begin
				if (creq.strobe[i]) begin
					if (dev_sel) begin
						dev[dev_idx][8*i +: 8] <= creq.data[8*i +: 8];
					end else begin
						mem[mem_idx][8*i +: 8] <= creq.data[8*i +: 8];
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

/* logic/cache_pkg.sv */
`default_nettype none

package cache_pkg;

	// basic bus words
	typedef logic [63:0] addr_t;
	typedef logic [63:0] word_t;
	// one bit per byte lane, nonzero means write
	typedef logic [7:0] strobe_t;

	// cache geometry
	// byte offset inside a 64-bit word
	localparam int align_bits = 3;
	// word offset inside a line
	localparam int word_bits = 3;
	// line index for 16 lines
	localparam int index_bits = 4;
	// cached region is decoded on bits 31:28, so the tag stops at bit 27
	localparam int cached_bits = 28;
	localparam int tag_bits = cached_bits - index_bits - word_bits - align_bits;
	localparam int words_per_line = 2 ** word_bits;
	localparam int num_lines = 2 ** index_bits;

	// memory slave sizes, in 64-bit words
	// 4 KiB cached backing store
	localparam int mem_words = 512;
	// uncached device registers
	localparam int dev_words = 16;
	localparam int mem_index_bits = $clog2(mem_words);
	localparam int dev_index_bits = $clog2(dev_words);

	// access size in bytes
	typedef enum logic [2:0] {
		msize_1 = 3'd0,
		msize_2 = 3'd1,
		msize_4 = 3'd2,
		msize_8 = 3'd3
	} msize_t;

	// beats minus one
	typedef enum logic [7:0] {
		mlen_1 = 8'd0,
		mlen_line = 8'(words_per_line - 1)
	} mlen_t;

	typedef enum logic [1:0] {
		burst_fixed = 2'b00,
		burst_incr = 2'b01
	} burst_t;

	// cached address seen either as a raw word or split into fields
	typedef union packed {
		addr_t raw;
		struct packed {
			logic [63:cached_bits] upper;
			logic [tag_bits-1:0] tag;
			logic [index_bits-1:0] index;
			logic [word_bits-1:0] word;
			logic [align_bits-1:0] offset;
		} field;
	} cache_addr_u;

	// cpu data bus request held as a level until data_ok
	typedef struct packed {
		logic valid;
		addr_t addr;
		msize_t size;
		strobe_t strobe;
		word_t data;
	} dbus_req_t;

	typedef struct packed {
		logic addr_ok;
		logic data_ok;
		word_t data;
	} dbus_resp_t;

	// cache bus toward memory with valid held for the whole burst
	typedef struct packed {
		logic valid;
		logic is_write;
		addr_t addr;
		msize_t size;
		strobe_t strobe;
		word_t data;
		mlen_t len;
		burst_t burst;
	} cbus_req_t;

	// one completed beat per ready cycle
	typedef struct packed {
		logic ready;
		logic last;
		word_t data;
	} cbus_resp_t;

endpackage

`default_nettype wire

/* logic/dcache.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache import cache_pkg::*; (
	input logic clk,
	input logic reset,
	input dbus_req_t dreq,
	output dbus_resp_t dresp,
	output cbus_req_t creq,
	input cbus_resp_t cresp
);

	typedef enum logic [1:0] {
		st_idle,
		st_fetch,
		st_writeback,
		st_uncached
	} state_t;

	state_t state, state_nxt;
	// beat number inside the current burst
	logic [word_bits-1:0] counter, counter_nxt;

	// per-line valid bits
	logic [num_lines-1:0] line_valid;

	cache_addr_u req_addr;
	cache_addr_u fetch_addr;
	cache_addr_u victim_addr;

	logic uncached;
	logic hit;
	logic victim;

	logic [tag_bits-1:0] tag_rd;
	logic tag_wen;
	logic [index_bits+word_bits-1:0] data_addr;
	strobe_t data_wen;
	word_t data_wr;
	word_t line_rd;

	// address decode
	assign req_addr.raw = dreq.addr;
	// only 0x0000_0000_8xxx_xxxx is cacheable
	assign uncached = dreq.addr[31:28] != 4'd8 || dreq.addr[63:32] != 32'd0;

	// line-aligned addresses for the two bursts
	always_comb begin
		fetch_addr = req_addr;
		fetch_addr.field.word = '0;
		fetch_addr.field.offset = '0;
		// victim shares index and upper bits, only the stored tag differs
		victim_addr = fetch_addr;
		victim_addr.field.tag = tag_rd;
	end

	// lookup
	assign hit = line_valid[req_addr.field.index] && tag_rd == req_addr.field.tag;
	// every valid line with another tag gets written back, no dirty bit
	assign victim = line_valid[req_addr.field.index] && tag_rd != req_addr.field.tag;

	// cpu word in idle, burst beat otherwise
	assign data_addr = (state == st_idle) ?
		{req_addr.field.index, req_addr.field.word} :
		{req_addr.field.index, counter};
	assign data_wr = (state == st_fetch) ? cresp.data : dreq.data;

	// miss sequencing
	always_comb begin
		state_nxt = state;
		counter_nxt = counter;
		data_wen = '0;
		tag_wen = 1'b0;
		case (state)
			st_idle: begin
				if (dreq.valid) begin
					if (uncached) begin
						state_nxt = st_uncached;
					end else if (hit) begin
						// store hit merges by strobe, read hit writes nothing
						data_wen = dreq.strobe;
					end else if (victim) begin
						state_nxt = st_writeback;
					end else begin
						state_nxt = st_fetch;
					end
				end
			end
			st_fetch: begin
				if (cresp.ready) begin
					// every fill beat lands in the data store
					data_wen = '1;
					counter_nxt = counter + word_bits'(1);
					if (cresp.last) begin
						// line complete so claim it for the new tag
						tag_wen = 1'b1;
						counter_nxt = '0;
						state_nxt = st_idle;
					end
				end
			end
			st_writeback: begin
				if (cresp.ready) begin
					counter_nxt = counter + word_bits'(1);
					if (cresp.last) begin
						counter_nxt = '0;
						state_nxt = st_fetch;
					end
				end
			end
			st_uncached: begin
				// single beat done on ready
				if (cresp.ready) begin
					state_nxt = st_idle;
				end
			end
			default: begin
				state_nxt = st_idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
			counter <= '0;
		end else begin
			state <= state_nxt;
			counter <= counter_nxt;
		end
	end

	// valid bits only ever get set, nothing invalidates a line
	always_ff @(posedge clk) begin
		if (reset) begin
			line_valid <= '0;
		end else if (tag_wen) begin
			line_valid[req_addr.field.index] <= 1'b1;
		end
	end

	// cpu response
	assign dresp.addr_ok = 1'b1;
	// hit is only trusted back in idle, after any fill has finished
	assign dresp.data_ok = dreq.valid &&
		((state == st_idle && !uncached && hit) ||
		(state == st_uncached && cresp.ready));
	assign dresp.data = (state == st_uncached) ? cresp.data : line_rd;

	// cache bus request
	always_comb begin
		creq.valid = state != st_idle;
		if (state == st_uncached) begin
			// device access goes out as the cpu gave it
			creq.is_write = |dreq.strobe;
			creq.addr = dreq.addr;
			creq.size = dreq.size;
			creq.strobe = dreq.strobe;
			creq.data = dreq.data;
			creq.len = mlen_1;
			creq.burst = burst_fixed;
		end else begin
			// full-line burst with writeback data read at the beat counter
			creq.is_write = state == st_writeback;
			creq.addr = (state == st_writeback) ? victim_addr.raw : fetch_addr.raw;
			creq.size = msize_8;
			creq.strobe = '1;
			creq.data = line_rd;
			creq.len = mlen_line;
			creq.burst = burst_incr;
		end
	end

	// tag store with one tag per line
	single_port_ram #(
		.addr_width(index_bits),
		.data_width(tag_bits),
		.byte_width(tag_bits)
	) tag_ram (
		.clk(clk),
		.addr(req_addr.field.index),
		.strobe(tag_wen),
		.wdata(req_addr.field.tag),
		.rdata(tag_rd)
	);

	// data store with byte lanes for store merges
	single_port_ram #(
		.addr_width(index_bits + word_bits),
		.data_width(64),
		.byte_width(8)
	) data_ram (
		.clk(clk),
		.addr(data_addr),
		.strobe(data_wen),
		.wdata(data_wr),
		.rdata(line_rd)
	);

endmodule

`default_nettype wire

/* logic/dcache_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_subsystem import cache_pkg::*; (
	input logic clk,
	input logic reset,
	input dbus_req_t dreq,
	output dbus_resp_t dresp
);

	// cache bus between the cache and the memory slave
	cbus_req_t creq;
	cbus_resp_t cresp;

	// cpu side cache
	dcache dcache_inst (
		.clk(clk),
		.reset(reset),
		.dreq(dreq),
		.dresp(dresp),
		.creq(creq),
		.cresp(cresp)
	);

	// memory behind it with cached store and device window
	burst_memory burst_memory_inst (
		.clk(clk),
		.reset(reset),
		.creq(creq),
		.cresp(cresp)
	);

endmodule

`default_nettype wire

/* logic/single_port_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module single_port_ram #(
	parameter int addr_width = 4,
	parameter int data_width = 64,
	parameter int byte_width = 8
) (
	input logic clk,
	input logic [addr_width-1:0] addr,
	// one enable per lane of byte_width bits
	input logic [data_width/byte_width-1:0] strobe,
	input logic [data_width-1:0] wdata,
	output logic [data_width-1:0] rdata
);

	// contents undefined until written
	logic [data_width-1:0] mem [2**addr_width];

	// asynchronous read port
	assign rdata = mem[addr];

	// lane-wise write
	// with byte_width == data_width this is a plain write enable
	always_ff @(posedge clk) begin
		for (int i = 0; i < data_width / byte_width; i++) begin
			if (strobe[i]) begin
				mem[addr][i*byte_width +: byte_width] <= wdata[i*byte_width +: byte_width];
			end
		end
	end

endmodule

`default_nettype wire

/* tb.f */
logic/cache_pkg.sv
logic/single_port_ram.sv
logic/dcache.sv
logic/burst_memory.sv
logic/dcache_subsystem.sv
bench/dcache_asserts.sv
bench/tb_dcache.sv
